//--- hdl/msx_glue_pkg.sv
`default_nettype none

package msx_glue_pkg;

   // ======================================
   // Host status word layout
   // ======================================
   localparam int STATUS_W       = 64;
   localparam int ST_RESET       = 0;
   localparam int ST_AR_LO       = 1;
   localparam int ST_SL_LO       = 3;
   localparam int ST_SCALE_LO    = 5;
   localparam int ST_VCROP       = 7;
   localparam int ST_TAPE_REWIND = 9;
   localparam int ST_DETACH      = 10;

   // Download slot of a cassette image
   localparam logic [5:0] CAS_INDEX = 6'd5;

   // Virtual drives served by the host
   localparam int VDNUM     = 6;
   localparam int VSD_DRIVE = 4;

   // ======================================
   // Video aspect and crop
   // ======================================
   localparam logic [11:0] ARX_NORMAL = 12'd400;
   localparam logic [11:0] ARX_WIDE   = 12'd340;
   localparam logic [11:0] ARY_NORMAL = 12'd300;

   // 4:3 modes of 1920x1440 and above fail the 1.5x width test
   localparam logic [11:0] WIDE_4X3_MIN_W = 12'd1440;

   // SD activity window in clk21m cycles, roughly 50 ms
   localparam int unsigned SD_ACT_CYCLES = 1000000;

   localparam int DDR3_ADDR_W = 28;

   typedef enum logic [1:0] {
      AR_ORIGINAL = 2'd0,
      AR_FULL     = 2'd1,
      AR_CUSTOM1  = 2'd2,
      AR_CUSTOM2  = 2'd3
   } ar_mode_t;

   // Video menu settings
   typedef struct packed {
      ar_mode_t   ar;
      logic [1:0] scanlines;
      logic [1:0] scale;
      logic       vcrop_en;
   } video_cfg_t;

   // Values handed to the HDMI scaler
   typedef struct packed {
      logic [11:0] arx;
      logic [11:0] ary;
      logic [9:0]  crop_size;
   } aspect_t;

   // One requester of the DDR3 read port
   typedef struct packed {
      logic [DDR3_ADDR_W-1:0] addr;
      logic                   rd;
   } ddr3_rd_t;

   typedef struct packed {
      logic sck;
      logic mosi;
      logic cs;
   } sd_pins_t;

endpackage

`default_nettype wire

//--- hdl/host_control.sv
`timescale 1ns/100ps
`default_nettype none

module host_control (
   input  logic [msx_glue_pkg::STATUS_W-1:0] status,
   input  logic                              forced_scandoubler,
   input  logic                              ext_reset,
   input  logic                              ioctl_download,
   input  logic [15:0]                       ioctl_index,
   input  msx_glue_pkg::ddr3_rd_t            dl_req,
   input  logic                              dl_active,
   input  msx_glue_pkg::ddr3_rd_t            cas_req,
   output msx_glue_pkg::video_cfg_t          video_cfg,
   output logic                              scandoubler,
   output logic                              sys_reset,
   output logic                              cas_rewind,
   output msx_glue_pkg::ddr3_rd_t            ddr3_sel
);

   import msx_glue_pkg::*;

   logic cas_download;

   // ======================================
   // Menu status decode
   // ======================================
   assign video_cfg.ar        = ar_mode_t'(status[ST_AR_LO +: 2]);
   assign video_cfg.scanlines = status[ST_SL_LO +: 2];
   assign video_cfg.scale     = status[ST_SCALE_LO +: 2];
   assign video_cfg.vcrop_en  = status[ST_VCROP];

   // Any scanline effect needs the doubled line rate
   assign scandoubler = forced_scandoubler | (|video_cfg.scanlines);

   // ======================================
   // Reset and cassette rewind
   // ======================================
   // Detach also restarts the machine
   assign sys_reset = ext_reset | status[ST_RESET] | status[ST_DETACH];

   // A new CAS file is loading
   assign cas_download = ioctl_download & (ioctl_index[5:0] == CAS_INDEX);

   // Tape goes back to the start on menu request, new image or reset
   assign cas_rewind = status[ST_TAPE_REWIND] | cas_download | sys_reset;

   // ======================================
   // DDR3 read port
   // ======================================
   // Download engine wins while it holds the port
   always_comb begin
      if (dl_active) begin
         ddr3_sel = dl_req;
      end else begin
         ddr3_sel = cas_req;
      end
   end

endmodule

`default_nettype wire

//--- hdl/video_crop.sv
`timescale 1ns/100ps
`default_nettype none

module video_crop (
   input  logic                     clk21m,
   input  logic                     rst_n,
   input  logic [11:0]              hdmi_width,
   input  logic [11:0]              hdmi_height,
   input  logic                     scandoubler,
   input  msx_glue_pkg::video_cfg_t video_cfg,
   output msx_glue_pkg::aspect_t    aspect
);

   import msx_glue_pkg::*;

   logic [12:0] wide_limit;
   logic        wide_screen;
   logic [9:0]  crop;
   logic        wide_ar;
   aspect_t     aspect_d;

   // Width at least 1.5 times the height, kept in 13 bits
   assign wide_limit  = {1'b0, hdmi_height} + {2'b00, hdmi_height[11:1]};
   assign wide_screen = ({1'b0, hdmi_width} >= wide_limit);

   // ======================================
   // Crop lookup by output height
   // ======================================
   always_comb begin
      crop    = 10'd0;
      wide_ar = 1'b0;
      if (wide_screen && !scandoubler) begin
         case (hdmi_height)
            12'd480:  crop = 10'd240;
            12'd600: begin
               crop    = 10'd200;
               wide_ar = video_cfg.vcrop_en;
            end
            12'd720:  crop = 10'd240;
            // NTSC shows only 250 lines of the 256
            12'd768:  crop = 10'd256;
            12'd800: begin
               crop    = 10'd200;
               wide_ar = video_cfg.vcrop_en;
            end
            12'd1080: crop = 10'd216;
            12'd1200: crop = 10'd240;
            default:  crop = 10'd0;
         endcase
      end else if ((hdmi_width >= WIDE_4X3_MIN_W) && !scandoubler) begin
         case (hdmi_height)
            12'd1440: crop = 10'd240;
            12'd1536: crop = 10'd256;
            default:  crop = 10'd0;
         endcase
      end
   end

   // ======================================
   // Aspect ratio
   // ======================================
   always_comb begin
      aspect_d.crop_size = video_cfg.vcrop_en ? crop : 10'd0;
      if (video_cfg.ar == AR_ORIGINAL) begin
         aspect_d.arx = wide_ar ? ARX_WIDE : ARX_NORMAL;
         aspect_d.ary = ARY_NORMAL;
      end else begin
         // Scaler reads small arx values as a custom ratio index
         aspect_d.arx = 12'(video_cfg.ar) - 12'd1;
         aspect_d.ary = 12'd0;
      end
   end

   always_ff @(posedge clk21m) begin
      if (!rst_n) begin
         aspect <= '0;
      end else begin
         aspect <= aspect_d;
      end
   end

endmodule

`default_nettype wire

//--- hdl/sd_route.sv
`timescale 1ns/100ps
`default_nettype none

module sd_route #(
   parameter int unsigned act_cycles = msx_glue_pkg::SD_ACT_CYCLES
) (
   input  logic                   clk21m,
   input  logic                   rst_n,
   input  logic                   img_mounted_vsd,
   input  logic [31:0]            img_size,
   input  logic                   spi_clk,
   input  logic                   spi_mosi,
   input  logic                   card_miso,
   input  logic                   vsd_miso,
   output logic                   core_miso,
   output msx_glue_pkg::sd_pins_t sd_pins,
   output logic                   led_user,
   output logic [1:0]             led_disk
);

   logic        vsd_sel;
   logic        sel_miso;
   logic        old_mosi;
   logic        old_miso;
   logic        spi_toggle;
   logic [31:0] act_cnt;
   logic        activity;

   // ======================================
   // Card selection
   // ======================================
   // Mounting a non-empty image switches to the virtual card
   always_ff @(posedge clk21m) begin
      if (!rst_n) begin
         vsd_sel <= 1'b0;
      end else if (img_mounted_vsd) begin
         vsd_sel <= |img_size;
      end
   end

   assign sel_miso  = vsd_sel ? vsd_miso : card_miso;
   assign core_miso = sel_miso;

   // Real card stays quiet while the image is in use
   assign sd_pins.sck  = spi_clk & ~vsd_sel;
   assign sd_pins.mosi = spi_mosi & ~vsd_sel;
   assign sd_pins.cs   = vsd_sel;

   // ======================================
   // Activity window
   // ======================================
   always_ff @(posedge clk21m) begin
      old_mosi <= spi_mosi;
      old_miso <= sel_miso;
   end

   assign spi_toggle = (old_mosi ^ spi_mosi) | (old_miso ^ sel_miso);

   // Saturates at act_cycles, which means idle
   always_ff @(posedge clk21m) begin
      if (!rst_n) begin
         act_cnt <= act_cycles;
      end else if (spi_toggle) begin
         act_cnt <= 32'd0;
      end else if (act_cnt < act_cycles) begin
         act_cnt <= act_cnt + 32'd1;
      end
   end

   assign activity = (act_cnt < act_cycles);

   assign led_user = vsd_sel & activity;
   assign led_disk = {1'b1, ~vsd_sel & activity};

endmodule

`default_nettype wire

//--- hdl/msx_glue_top.sv
`timescale 1ns/100ps
`default_nettype none

module msx_glue_top #(
   parameter int unsigned act_cycles = msx_glue_pkg::SD_ACT_CYCLES
) (
   input  logic                              clk21m,
   input  logic                              rst_n,
   // Host menu and downloads
   input  logic [msx_glue_pkg::STATUS_W-1:0] status,
   input  logic                              forced_scandoubler,
   input  logic                              ext_reset,
   input  logic                              ioctl_download,
   input  logic [15:0]                       ioctl_index,
   input  msx_glue_pkg::ddr3_rd_t            dl_req,
   input  logic                              dl_active,
   input  msx_glue_pkg::ddr3_rd_t            cas_req,
   output logic                              scandoubler,
   output logic                              sys_reset,
   output logic                              cas_rewind,
   output msx_glue_pkg::ddr3_rd_t            ddr3_sel,
   // Video
   input  logic [11:0]                       hdmi_width,
   input  logic [11:0]                       hdmi_height,
   output msx_glue_pkg::aspect_t             aspect,
   output logic [1:0]                        vga_sl,
   output logic [1:0]                        scale,
   // SD card and image
   input  logic [msx_glue_pkg::VDNUM-1:0]    img_mounted,
   input  logic [31:0]                       img_size,
   input  logic                              spi_clk,
   input  logic                              spi_mosi,
   input  logic                              card_miso,
   input  logic                              vsd_miso,
   output logic                              core_miso,
   output msx_glue_pkg::sd_pins_t            sd_pins,
   output logic                              led_user,
   output logic [1:0]                        led_disk
);

   import msx_glue_pkg::*;

   video_cfg_t video_cfg;

   assign vga_sl = video_cfg.scanlines;
   assign scale  = video_cfg.scale;

   host_control i_host_control (
      .status             (status),
      .forced_scandoubler (forced_scandoubler),
      .ext_reset          (ext_reset),
      .ioctl_download     (ioctl_download),
      .ioctl_index        (ioctl_index),
      .dl_req             (dl_req),
      .dl_active          (dl_active),
      .cas_req            (cas_req),
      .video_cfg          (video_cfg),
      .scandoubler        (scandoubler),
      .sys_reset          (sys_reset),
      .cas_rewind         (cas_rewind),
      .ddr3_sel           (ddr3_sel)
   );

   video_crop i_video_crop (
      .clk21m      (clk21m),
      .rst_n       (rst_n),
      .hdmi_width  (hdmi_width),
      .hdmi_height (hdmi_height),
      .scandoubler (scandoubler),
      .video_cfg   (video_cfg),
      .aspect      (aspect)
   );

   // Drive slot VSD_DRIVE carries the SD card image
   sd_route #(
      .act_cycles (act_cycles)
   ) i_sd_route (
      .clk21m          (clk21m),
      .rst_n           (rst_n),
      .img_mounted_vsd (img_mounted[VSD_DRIVE]),
      .img_size        (img_size),
      .spi_clk         (spi_clk),
      .spi_mosi        (spi_mosi),
      .card_miso       (card_miso),
      .vsd_miso        (vsd_miso),
      .core_miso       (core_miso),
      .sd_pins         (sd_pins),
      .led_user        (led_user),
      .led_disk        (led_disk)
   );

endmodule

`default_nettype wire

//--- verif/tb_msx_glue.sv
`timescale 1ns/100ps
`default_nettype none

module tb_msx_glue;

   import msx_glue_pkg::*;

   localparam int ACT_CYCLES  = 20;
   localparam int LINE_CYCLES = 60;

   // One line of the pattern file
   typedef struct packed {
      logic [31:0] test;
      logic [31:0] op;
      logic [63:0] in0;
      logic [31:0] in1;
      logic [31:0] in2;
      logic [31:0] in3;
      logic [31:0] exp0;
      logic [31:0] exp1;
      logic [31:0] exp2;
   } pattern_t;

   logic                clk21m;
   logic                rst_n;
   logic [STATUS_W-1:0] status;
   logic                forced_scandoubler;
   logic                ext_reset;
   logic                ioctl_download;
   logic [15:0]         ioctl_index;
   ddr3_rd_t            dl_req;
   logic                dl_active;
   ddr3_rd_t            cas_req;
   logic                scandoubler;
   logic                sys_reset;
   logic                cas_rewind;
   ddr3_rd_t            ddr3_sel;
   logic [11:0]         hdmi_width;
   logic [11:0]         hdmi_height;
   aspect_t             aspect;
   logic [1:0]          vga_sl;
   logic [1:0]          scale;
   logic [VDNUM-1:0]    img_mounted;
   logic [31:0]         img_size;
   logic                spi_clk;
   logic                spi_mosi;
   logic                card_miso;
   logic                vsd_miso;
   logic                core_miso;
   sd_pins_t            sd_pins;
   logic                led_user;
   logic [1:0]          led_disk;

   pattern_t    patterns[$];
   int          errors;
   int          checks;
   int          line_no;
   bit          loaded;
   logic [31:0] lfsr_state;

   msx_glue_top #(
      .act_cycles (ACT_CYCLES)
   ) i_dut (.*);

   initial begin
      clk21m = 1'b0;
      forever #5 clk21m = ~clk21m;
   end

   // ========================================
   // Helpers
   // ========================================
   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   task automatic take_random(input int nbits, output logic [63:0] value);
      value = '0;
      for (int i = 0; i < nbits; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         value = {value[62:0], lfsr_state[0]};
      end
   endtask

   function automatic string tag_for(input pattern_t p, input string field);
      return $sformatf("test %0d line %0d %s", p.test, line_no, field);
   endfunction

   task automatic check_eq(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
      end
   endtask

   task automatic load_patterns();
      int          fd;
      int          n;
      string       line;
      logic [31:0] t, op, a1, a2, a3, e0, e1, e2;
      logic [63:0] a0;
      fd = $fopen("verif/msx_glue_patterns.txt", "r");
      if (fd == 0) begin
         errors++;
         $display("Cannot open the pattern file verif/msx_glue_patterns.txt");
         return;
      end
      while (!$feof(fd)) begin
         line = "";
         n = $fgets(line, fd);
         // Skip comments and blank lines
         if (n > 0 && line.len() > 0 && line[0] != "#") begin
            if ($sscanf(line, "%d %d %h %h %h %h %h %h %h",
                        t, op, a0, a1, a2, a3, e0, e1, e2) == 9) begin
               patterns.push_back({t, op, a0, a1, a2, a3, e0, e1, e2});
            end
         end
      end
      $fclose(fd);
   endtask

   // One-cycle mount pulse on the SD image slot
   task automatic pulse_mount(input logic [31:0] size);
      img_size = size;
      img_mounted[VSD_DRIVE] = 1'b1;
      @(negedge clk21m);
      img_mounted = '0;
      @(negedge clk21m);
   endtask

   // ========================================
   // Operations entered on a falling edge
   // ========================================
   task automatic apply_video(input pattern_t p);
      logic [1:0] sl;
      logic       sd_exp;
      status = p.in0;
      forced_scandoubler = p.in1[0];
      hdmi_width = p.in2[11:0];
      hdmi_height = p.in3[11:0];
      sl = p.in0[ST_SL_LO +: 2];
      sd_exp = p.in1[0] | (|sl);
      // Crop result is registered
      repeat (2) @(negedge clk21m);
      check_eq(tag_for(p, "arx"), 64'(p.exp0[11:0]), 64'(aspect.arx));
      check_eq(tag_for(p, "ary"), 64'(p.exp1[11:0]), 64'(aspect.ary));
      check_eq(tag_for(p, "crop_size"), 64'(p.exp2[9:0]), 64'(aspect.crop_size));
      check_eq(tag_for(p, "scandoubler"), 64'(sd_exp), 64'(scandoubler));
      check_eq(tag_for(p, "vga_sl"), 64'(sl), 64'(vga_sl));
      check_eq(tag_for(p, "scale"), 64'(p.in0[ST_SCALE_LO +: 2]), 64'(scale));
   endtask

   task automatic select_card(input pattern_t p);
      vsd_miso = p.in1[0];
      card_miso = p.in2[0];
      spi_clk = p.in3[0];
      spi_mosi = p.in3[0];
      pulse_mount(p.in0[31:0]);
      check_eq(tag_for(p, "cs"), 64'(p.exp0[0]), 64'(sd_pins.cs));
      check_eq(tag_for(p, "core_miso"), 64'(p.exp1[0]), 64'(core_miso));
      check_eq(tag_for(p, "sck"), 64'(p.exp2[0]), 64'(sd_pins.sck));
      check_eq(tag_for(p, "mosi"), 64'(p.exp2[0]), 64'(sd_pins.mosi));
   endtask

   task automatic exercise_leds(input pattern_t p);
      logic [63:0] bits;
      int          n;
      logic        moved;
      n = int'(p.in0[31:0]);
      spi_clk = 1'b0;
      pulse_mount(p.in1);
      repeat (ACT_CYCLES + 5) @(negedge clk21m);
      check_eq(tag_for(p, "idle led_user"), 64'd0, 64'(led_user));
      check_eq(tag_for(p, "idle led_disk"), 64'd2, 64'(led_disk));
      moved = 1'b0;
      // Burst is shorter than the window so the LED stays lit after a change
      for (int i = 0; i < n; i++) begin
         take_random(1, bits);
         if (bits[0] !== spi_mosi) begin
            moved = 1'b1;
         end
         spi_mosi = bits[0];
         @(negedge clk21m);
         check_eq(tag_for(p, "burst led_user"), 64'(p.exp0[0] & moved), 64'(led_user));
         check_eq(tag_for(p, "burst led_disk"), 64'({1'b1, p.exp1[0] & moved}),
                  64'(led_disk));
      end
      // Last toggle starts the window
      spi_mosi = ~spi_mosi;
      for (int i = 0; i < ACT_CYCLES; i++) begin
         @(negedge clk21m);
         check_eq(tag_for(p, "busy led_user"), 64'(p.exp0[0]), 64'(led_user));
         check_eq(tag_for(p, "busy led_disk"), 64'({1'b1, p.exp1[0]}), 64'(led_disk));
      end
      repeat (3) @(negedge clk21m);
      check_eq(tag_for(p, "quiet led_user"), 64'd0, 64'(led_user));
      check_eq(tag_for(p, "quiet led_disk"), 64'd2, 64'(led_disk));
   endtask

   task automatic drive_control(input pattern_t p);
      logic [63:0] r;
      ddr3_rd_t    want;
      take_random(DDR3_ADDR_W + 1, r);
      dl_req = r[DDR3_ADDR_W:0];
      take_random(DDR3_ADDR_W + 1, r);
      cas_req = r[DDR3_ADDR_W:0];
      status = p.in0;
      ext_reset = p.in1[0];
      ioctl_download = p.in1[1];
      dl_active = p.in1[2];
      ioctl_index = p.in2[15:0];
      want = p.exp2[0] ? dl_req : cas_req;
      @(negedge clk21m);
      check_eq(tag_for(p, "sys_reset"), 64'(p.exp0[0]), 64'(sys_reset));
      check_eq(tag_for(p, "cas_rewind"), 64'(p.exp1[0]), 64'(cas_rewind));
      check_eq(tag_for(p, "ddr3_sel"), 64'(want), 64'(ddr3_sel));
   endtask

   // ========================================
   // Main sequence
   // ========================================
   initial begin
      errors = 0;
      checks = 0;
      line_no = 0;
      loaded = 1'b0;
      lfsr_state = 32'hb6f2;
      rst_n = 1'b0;
      status = '0;
      forced_scandoubler = 1'b0;
      ext_reset = 1'b0;
      ioctl_download = 1'b0;
      ioctl_index = '0;
      dl_req = '0;
      dl_active = 1'b0;
      cas_req = '0;
      hdmi_width = '0;
      hdmi_height = '0;
      img_mounted = '0;
      img_size = '0;
      spi_clk = 1'b0;
      spi_mosi = 1'b0;
      card_miso = 1'b0;
      vsd_miso = 1'b0;
      load_patterns();
      loaded = 1'b1;
      repeat (10) @(negedge clk21m);
      check_eq("reset aspect", 64'd0, {28'd0, aspect});
      rst_n = 1'b1;
      @(negedge clk21m);
      check_eq("reset led_user", 64'd0, 64'(led_user));
      check_eq("reset led_disk", 64'd2, 64'(led_disk));
      foreach (patterns[i]) begin
         line_no = i + 1;
         case (patterns[i].op)
            32'd1: apply_video(patterns[i]);
            32'd3: select_card(patterns[i]);
            32'd4: exercise_leds(patterns[i]);
            32'd5: drive_control(patterns[i]);
            default: begin
               errors++;
               $display("Pattern line %0d has an unknown operation %0d", line_no,
                        patterns[i].op);
            end
         endcase
         @(negedge clk21m);
      end
      if (patterns.size() == 0) begin
         errors++;
         $display("No pattern lines were loaded");
      end
      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

   // Budget scales with the number of pattern lines
   initial begin
      wait (loaded);
      repeat (patterns.size() * LINE_CYCLES + 200) @(posedge clk21m);
      $display("Watchdog timeout, the pattern run did not finish in time");
      $display("test failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- verif/msx_glue_patterns.txt
# test op in0 in1 in2 in3 exp0 exp1 exp2 (test and op decimal, the rest hex)
# op1 video: status forced width height | arx ary crop    op3 sd: size vsd card spi | cs miso sck
# op4 leds: bits size - - | user disk -    op5 ctrl: status {active,dl,ext} index - | rst rew dl_sel
1 1 80 0 2d0 1e0 190 12c f0
1 1 80 0 400 258 154 12c c8
1 1 80 0 500 2d0 190 12c f0
1 1 80 0 556 300 190 12c 100
1 1 80 0 500 320 154 12c c8
1 1 80 0 780 438 190 12c d8
1 1 80 0 780 4b0 190 12c f0
1 1 80 0 780 5a0 190 12c f0
1 1 80 0 800 600 190 12c 100
1 1 0 0 400 258 190 12c 0
1 1 0 0 500 320 190 12c 0
1 1 0 0 780 438 190 12c 0
1 1 88 0 780 438 190 12c 0
1 1 80 1 780 438 190 12c 0
1 1 80 0 400 300 190 12c 0
2 1 82 0 780 438 0 0 d8
2 1 a4 0 780 438 1 0 d8
2 1 c6 0 780 438 2 0 d8
2 1 9a 0 780 438 0 0 0
3 3 1000 1 0 1 1 1 0
3 3 1000 0 1 1 1 0 0
3 3 0 1 0 1 0 0 1
3 3 0 0 1 1 0 1 1
4 4 10 0 0 0 0 1 0
4 4 10 200 0 0 1 0 0
5 5 0 0 0 0 0 0 0
5 5 1 0 0 0 1 1 0
5 5 400 0 0 0 1 1 0
5 5 200 0 0 0 0 1 0
5 5 0 1 0 0 1 1 0
5 5 0 2 5 0 0 1 0
5 5 0 2 3 0 0 0 0
5 5 0 0 5 0 0 0 0
5 5 0 4 0 0 0 0 1
5 5 0 6 45 0 0 1 1

//--- sources.f
hdl/msx_glue_pkg.sv
hdl/host_control.sv
hdl/video_crop.sv
hdl/sd_route.sv
hdl/msx_glue_top.sv
verif/tb_msx_glue.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --timescale 1ns/100ps --top-module tb_msx_glue \
   -f sources.f -o sim_tb
./obj_dir/sim_tb > sim.log
cat sim.log
if grep -qx "test passed" sim.log; then
   echo "Simulation result: PASS"
else
   echo "Simulation result: FAIL"
   exit 1
fi
